// File: udp_ip_tx.f
verilog/udp_tx_pkg.sv
verilog/byte_stream_if.sv
verilog/udp_hdr_regs.sv
verilog/udp_tx_ctrl.sv
verilog/axis_skid_buffer.sv
verilog/udp_ip_tx.sv
tb/udp_ip_tx_sva.sv
tb/tb_udp_ip_tx.sv

// File: Makefile
# Verilator build and run for the UDP transmit framer
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_udp_ip_tx
FILELIST  := udp_ip_tx.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN) tb/udp_tx_trace.txt
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Errors found" $(LOG); then exit 1; fi
	@grep -q "No errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/udp_tx_trace.txt
# hex: source_ip dest_ip ttl protocol identification src_port dst_port udp_length checksum
# decimal: payload bytes actually sent, back-pressure (0 none, 1 random)
c0a80001 c0a80002 40 11 0001 04d2 1f90 0018 0000 16 0
0a000001 0a0000fe 80 11 0002 1388 0035 0010 beef 8 1
c0a80a0a c0a80a14 20 11 0003 abcd 1234 000c 5a5a 10 0
ac100001 ac1000ff ff 11 0004 0007 0009 0014 0102 30 1
c0a80001 c0a80003 01 11 0005 8000 0001 0020 ffff 5 0
0a0a0a0a 0b0b0b0b 3f 11 0006 0fff f000 0030 1234 17 1
7f000001 7f000001 40 11 0007 0050 0050 0009 0000 1 0
c0a80101 c0a80102 40 11 0008 c350 c351 000a 9876 3 1
0a000002 0a000003 40 11 0009 2710 2711 0030 4321 40 1
c0a80001 c0a80004 40 11 000a 0101 0202 0010 0000 1 1

// File: tb/tb_udp_ip_tx.sv
// UDP framer testbench
module tb_udp_ip_tx;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 udp_hdr_valid, udp_hdr_ready;
    udp_tx_pkg::ip_hdr_t  ip_hdr_drv;
    udp_tx_pkg::udp_hdr_t udp_hdr_drv;
    logic [7:0]           udp_payload_tdata;
    logic                 udp_payload_tvalid, udp_payload_tlast, udp_payload_tuser;
    logic                 udp_payload_tready;
    logic                 ip_hdr_valid;
    logic                 ip_hdr_ready = 1'b0;
    logic [31:0]          out_ip_source_ip, out_ip_dest_ip;
    logic [7:0]           out_ip_ttl, out_ip_protocol;
    logic [15:0]          out_ip_identification, ip_length;
    logic [7:0]           ip_payload_tdata;
    logic                 ip_payload_tvalid, ip_payload_tlast, ip_payload_tuser;
    logic                 ip_payload_tready = 1'b0;
    logic                 busy, error_payload_early_termination;
    logic                 bp_random = 1'b0;
    udp_tx_pkg::ip_hdr_t  hdr_got;
    udp_tx_pkg::ip_beat_t beat_got;

    // expectations in output order
    udp_tx_pkg::ip_hdr_t  exp_hdr_q[$];
    logic [15:0]          exp_len_q[$];
    udp_tx_pkg::ip_beat_t exp_beat_q[$];
    int                   err_pulses = 0;
    int                   err_expected = 0;
    int                   limit_cycles = 0;

    udp_ip_tx dut_i (
        .ip_source_ip      (ip_hdr_drv.source_ip),
        .ip_dest_ip        (ip_hdr_drv.dest_ip),
        .ip_ttl            (ip_hdr_drv.ttl),
        .ip_protocol       (ip_hdr_drv.protocol),
        .ip_identification (ip_hdr_drv.identification),
        .udp_source_port   (udp_hdr_drv.source_port),
        .udp_dest_port     (udp_hdr_drv.dest_port),
        .udp_length        (udp_hdr_drv.length),
        .udp_checksum      (udp_hdr_drv.checksum),
        .*
    );

    assign hdr_got  = {out_ip_source_ip, out_ip_dest_ip, out_ip_ttl, out_ip_protocol,
                       out_ip_identification};
    assign beat_got = {ip_payload_tdata, ip_payload_tlast, ip_payload_tuser};

    always #10 clk = ~clk;

    task automatic abort_run();
        $display("Errors found");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic compare_hdr(udp_tx_pkg::ip_hdr_t got, udp_tx_pkg::ip_hdr_t exp);
        if (got !== exp) begin
            $display("MISMATCH out_ip header fields: got %h expected %h", got, exp);
            abort_run();
        end
    endtask

    task automatic compare_beat(udp_tx_pkg::ip_beat_t got, udp_tx_pkg::ip_beat_t exp);
        if (got !== exp) begin
            $display("MISMATCH ip_payload {tdata,tlast,tuser}: got %h expected %h", got, exp);
            abort_run();
        end
    endtask

    task automatic compare_len(logic [15:0] got, logic [15:0] exp);
        if (got !== exp) begin
            $display("MISMATCH ip_length: got %h expected %h", got, exp);
            abort_run();
        end
    endtask

    task automatic compare_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    // output pacing is random or always ready
    always @(posedge clk) begin
        if (bp_random) begin
            ip_payload_tready <= 1'($urandom_range(1, 0));
            ip_hdr_ready      <= 1'($urandom_range(1, 0));
        end else begin
            ip_payload_tready <= 1'b1;
            ip_hdr_ready      <= 1'b1;
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            if (ip_hdr_valid && ip_hdr_ready) begin
                if (exp_hdr_q.size() == 0) begin
                    $display("an IP header came out with no frame waiting for it");
                    abort_run();
                end else begin
                    compare_hdr(hdr_got, exp_hdr_q.pop_front());
                    compare_len(ip_length, exp_len_q.pop_front());
                end
            end
            if (ip_payload_tvalid && ip_payload_tready) begin
                if (exp_beat_q.size() == 0) begin
                    $display("an output byte came out after the expected stream ended");
                    abort_run();
                end else begin
                    compare_beat(beat_got, exp_beat_q.pop_front());
                end
            end
            if (error_payload_early_termination) begin
                err_pulses++;
            end
        end
    end

    task automatic run_frame(udp_tx_pkg::ip_hdr_t ip, udp_tx_pkg::udp_hdr_t udp,
                             int plen, int mode);
        logic [7:0]           pay[$];
        udp_tx_pkg::ip_beat_t b;
        int                   kept;
        logic                 short_frame;
        // room left for payload after the UDP header
        kept        = int'(udp.length) - udp_tx_pkg::UDP_HDR_BYTES;
        short_frame = plen < kept;
        if (short_frame) begin
            kept = plen;
        end
        for (int i = 0; i < plen; i++) begin
            pay.push_back(8'($urandom_range(255, 0)));
        end
        exp_hdr_q.push_back(ip);
        exp_len_q.push_back(16'(int'(udp.length) + udp_tx_pkg::IP_HDR_BYTES));
        // header bytes go out big endian
        b = '0;
        for (int i = 0; i < udp_tx_pkg::UDP_HDR_BYTES; i++) begin
            b.data = udp[63 - 8 * i -: 8];
            exp_beat_q.push_back(b);
        end
        for (int i = 0; i < kept; i++) begin
            b.data = pay[i];
            b.last = (i == kept - 1);
            b.user = b.last & short_frame;
            exp_beat_q.push_back(b);
        end
        if (short_frame) begin
            err_expected++;
        end
        bp_random <= (mode != 0);
        @(posedge clk);
        ip_hdr_drv    <= ip;
        udp_hdr_drv   <= udp;
        udp_hdr_valid <= 1'b1;
        do begin
            @(posedge clk);
        end while (!udp_hdr_ready);
        udp_hdr_valid <= 1'b0;
        for (int i = 0; i < plen; i++) begin
            udp_payload_tdata  <= pay[i];
            udp_payload_tvalid <= 1'b1;
            udp_payload_tlast  <= (i == plen - 1);
            do begin
                @(posedge clk);
            end while (!udp_payload_tready);
            compare_flag("busy", busy, 1'b1);
        end
        udp_payload_tvalid <= 1'b0;
        udp_payload_tlast  <= 1'b0;
        // status registers settle one cycle after the last input beat
        @(posedge clk);
        compare_flag("busy", busy, 1'b0);
        compare_flag("error_payload_early_termination", error_payload_early_termination,
                     short_frame);
    endtask

    initial begin
        int                   fd, n, plen, mode, budget;
        string                line;
        logic [31:0]          sip, dip;
        logic [7:0]           ttl, proto;
        logic [15:0]          ident, sport, dport, ulen, csum;
        udp_tx_pkg::ip_hdr_t  trace_ip_q[$];
        udp_tx_pkg::udp_hdr_t trace_udp_q[$];
        int                   plen_q[$], mode_q[$];
        void'($urandom(33281));
        rst                = 1'b1;
        udp_hdr_valid      = 1'b0;
        ip_hdr_drv         = '0;
        udp_hdr_drv        = '0;
        udp_payload_tdata  = '0;
        udp_payload_tvalid = 1'b0;
        udp_payload_tlast  = 1'b0;
        udp_payload_tuser  = 1'b0;
        budget             = 10;
        fd = $fopen("tb/udp_tx_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file tb/udp_tx_trace.txt");
            abort_run();
        end
        while (!$feof(fd)) begin
            line = "";
            n    = $fgets(line, fd);
            n    = $sscanf(line, "%h %h %h %h %h %h %h %h %h %d %d",
                           sip, dip, ttl, proto, ident, sport, dport, ulen, csum, plen, mode);
            // comment and blank lines do not scan
            if (n == 11) begin
                trace_ip_q.push_back(udp_tx_pkg::ip_hdr_t'({sip, dip, ttl, proto, ident}));
                trace_udp_q.push_back(udp_tx_pkg::udp_hdr_t'({sport, dport, ulen, csum}));
                plen_q.push_back(plen);
                mode_q.push_back(mode);
                budget += 200 + plen;
            end
        end
        $fclose(fd);
        if (trace_ip_q.size() == 0) begin
            $display("the trace file holds no frames");
            abort_run();
        end
        limit_cycles = budget;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        foreach (trace_ip_q[i]) begin
            run_frame(trace_ip_q[i], trace_udp_q[i], plen_q[i], mode_q[i]);
        end
        // let the output side drain
        while (exp_beat_q.size() != 0 || exp_hdr_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (5) @(posedge clk);
        if (err_pulses != err_expected) begin
            $display("MISMATCH error_payload_early_termination pulses: got %h expected %h",
                     err_pulses, err_expected);
            abort_run();
        end else begin
            $display("No errors");
            $finish;
        end
    end

    // watchdog
    initial begin
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout, the trace did not finish within %0d cycles", limit_cycles);
        abort_run();
    end

endmodule

// File: tb/udp_ip_tx_sva.sv
// Framer handshake assertions
module udp_ip_tx_sva (
    input logic        clk,
    input logic        rst,
    input logic        udp_hdr_ready,
    input logic        udp_payload_tready,
    input logic        ip_hdr_valid,
    input logic        ip_hdr_ready,
    input logic [15:0] ip_length,
    input logic [7:0]  ip_payload_tdata,
    input logic        ip_payload_tvalid,
    input logic        ip_payload_tlast,
    input logic        ip_payload_tuser,
    input logic        ip_payload_tready,
    input logic        busy,
    input logic        error_payload_early_termination
);

    // header held with its length until taken
    hdr_held: assert property (@(posedge clk) disable iff (rst)
        ip_hdr_valid && !ip_hdr_ready |=> ip_hdr_valid && $stable(ip_length))
        else $error("ip header dropped or changed before acceptance");

    beat_held: assert property (@(posedge clk) disable iff (rst)
        ip_payload_tvalid && !ip_payload_tready |=> ip_payload_tvalid
            && $stable({ip_payload_tdata, ip_payload_tlast, ip_payload_tuser}))
        else $error("output beat dropped or changed before acceptance");

    // no new header while a frame is running
    no_hdr_when_busy: assert property (@(posedge clk) disable iff (rst)
        busy |-> !udp_hdr_ready)
        else $error("udp_hdr_ready high while busy");

    quiet_after_reset: assert property (@(posedge clk)
        rst |=> !udp_hdr_ready && !udp_payload_tready && !ip_hdr_valid
            && !ip_payload_tvalid && !busy && !error_payload_early_termination)
        else $error("outputs not low after reset");

endmodule

bind udp_ip_tx udp_ip_tx_sva sva_i (.*);

// File: verilog/udp_ip_tx.sv
// UDP to IP transmit framer
module udp_ip_tx (
    input  logic        clk,
    input  logic        rst,

    // UDP frame in
    input  logic        udp_hdr_valid,
    output logic        udp_hdr_ready,
    input  logic [31:0] ip_source_ip,
    input  logic [31:0] ip_dest_ip,
    input  logic [7:0]  ip_ttl,
    input  logic [7:0]  ip_protocol,
    input  logic [15:0] ip_identification,
    input  logic [15:0] udp_source_port,
    input  logic [15:0] udp_dest_port,
    input  logic [15:0] udp_length,
    input  logic [15:0] udp_checksum,
    input  logic [7:0]  udp_payload_tdata,
    input  logic        udp_payload_tvalid,
    input  logic        udp_payload_tlast,
    input  logic        udp_payload_tuser,
    output logic        udp_payload_tready,

    // IP frame out
    output logic        ip_hdr_valid,
    input  logic        ip_hdr_ready,
    output logic [31:0] out_ip_source_ip,
    output logic [31:0] out_ip_dest_ip,
    output logic [7:0]  out_ip_ttl,
    output logic [7:0]  out_ip_protocol,
    output logic [15:0] out_ip_identification,
    output logic [15:0] ip_length,
    output logic [7:0]  ip_payload_tdata,
    output logic        ip_payload_tvalid,
    output logic        ip_payload_tlast,
    output logic        ip_payload_tuser,
    input  logic        ip_payload_tready,

    // status
    output logic        busy,
    output logic        error_payload_early_termination
);

    udp_tx_pkg::ip_hdr_t  ip_hdr_in;
    udp_tx_pkg::ip_hdr_t  ip_hdr_out;
    udp_tx_pkg::udp_hdr_t udp_hdr_in;
    udp_tx_pkg::udp_hdr_t udp_hdr_stored;
    udp_tx_pkg::ip_beat_t out_beat;
    logic                 store;
    logic                 hdr_pending;

    byte_stream_if #(.beat_t(udp_tx_pkg::ip_beat_t)) stream ();

    assign ip_hdr_in.source_ip      = ip_source_ip;
    assign ip_hdr_in.dest_ip        = ip_dest_ip;
    assign ip_hdr_in.ttl            = ip_ttl;
    assign ip_hdr_in.protocol       = ip_protocol;
    assign ip_hdr_in.identification = ip_identification;

    assign udp_hdr_in.source_port = udp_source_port;
    assign udp_hdr_in.dest_port   = udp_dest_port;
    assign udp_hdr_in.length      = udp_length;
    assign udp_hdr_in.checksum    = udp_checksum;

    udp_hdr_regs hdr_regs_i (
        .clk          (clk),
        .rst          (rst),
        .store        (store),
        .ip_hdr_in    (ip_hdr_in),
        .udp_hdr_in   (udp_hdr_in),
        .ip_hdr_out   (ip_hdr_out),
        .ip_length    (ip_length),
        .udp_hdr_out  (udp_hdr_stored),
        .ip_hdr_valid (ip_hdr_valid),
        .ip_hdr_ready (ip_hdr_ready),
        .hdr_pending  (hdr_pending)
    );

    udp_tx_ctrl ctrl_i (
        .clk                             (clk),
        .rst                             (rst),
        .udp_hdr_valid                   (udp_hdr_valid),
        .udp_hdr_ready                   (udp_hdr_ready),
        .udp_source_port_in              (udp_source_port),
        .store                           (store),
        .udp_hdr                         (udp_hdr_stored),
        .hdr_pending                     (hdr_pending),
        .tdata                           (udp_payload_tdata),
        .tvalid                          (udp_payload_tvalid),
        .tlast                           (udp_payload_tlast),
        .tuser                           (udp_payload_tuser),
        .tready                          (udp_payload_tready),
        .out_stream                      (stream.source),
        .busy                            (busy),
        .error_payload_early_termination (error_payload_early_termination)
    );

    axis_skid_buffer #(.beat_t(udp_tx_pkg::ip_beat_t)) skid_i (
        .clk       (clk),
        .rst       (rst),
        .in_stream (stream.sink),
        .out_beat  (out_beat),
        .out_valid (ip_payload_tvalid),
        .out_ready (ip_payload_tready)
    );

    assign out_ip_source_ip      = ip_hdr_out.source_ip;
    assign out_ip_dest_ip        = ip_hdr_out.dest_ip;
    assign out_ip_ttl            = ip_hdr_out.ttl;
    assign out_ip_protocol       = ip_hdr_out.protocol;
    assign out_ip_identification = ip_hdr_out.identification;

    assign ip_payload_tdata = out_beat.data;
    assign ip_payload_tlast = out_beat.last;
    assign ip_payload_tuser = out_beat.user;

endmodule

// File: verilog/axis_skid_buffer.sv
// Output skid buffer
module axis_skid_buffer #(
    parameter type beat_t = logic [7:0]
) (
    input  logic        clk,
    input  logic        rst,

    byte_stream_if.sink in_stream,

    output beat_t       out_beat,
    output logic        out_valid,
    input  logic        out_ready
);

    beat_t temp_beat;
    logic  temp_valid;

    // room next cycle if the output drains, both registers are empty,
    // or the temp register is free and nothing lands in the output now
    assign in_stream.ready_early = out_ready
                                 | (~temp_valid & ~out_valid)
                                 | (~temp_valid & ~in_stream.valid);

    always_ff @(posedge clk) begin
        if (rst) begin
            in_stream.ready <= 1'b0;
            out_valid       <= 1'b0;
            temp_valid      <= 1'b0;
        end else begin
            in_stream.ready <= in_stream.ready_early;
            if (in_stream.ready) begin
                if (out_ready || !out_valid) begin
                    out_valid <= in_stream.valid;
                end else begin
                    // output stalled, park the beat in flight
                    temp_valid <= in_stream.valid;
                end
            end else if (out_ready) begin
                out_valid  <= temp_valid;
                temp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_stream.ready) begin
            if (out_ready || !out_valid) begin
                out_beat <= in_stream.beat;
            end else begin
                temp_beat <= in_stream.beat;
            end
        end else if (out_ready) begin
            out_beat <= temp_beat;
        end
    end

endmodule

// File: verilog/udp_tx_ctrl.sv
// UDP header serializer and payload framer
module udp_tx_ctrl (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 udp_hdr_valid,
    output logic                 udp_hdr_ready,
    // live port value feeds the first byte before the header registers load
    input  logic [15:0]          udp_source_port_in,

    output logic                 store,
    input  udp_tx_pkg::udp_hdr_t udp_hdr,
    input  logic                 hdr_pending,

    input  logic [7:0]           tdata,
    input  logic                 tvalid,
    input  logic                 tlast,
    input  logic                 tuser,
    output logic                 tready,

    byte_stream_if.source        out_stream,

    output logic                 busy,
    output logic                 error_payload_early_termination
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HEADER,
        ST_PAYLOAD,
        ST_DISCARD
    } state_t;

    state_t state, state_next;

    // counts header and payload bytes together, as the UDP length does
    logic [15:0] frame_ptr, frame_ptr_next;

    logic        hdr_ready_next;
    logic        tready_next;
    logic        error_next;
    logic        store_last;
    logic [7:0]  last_data;

    logic [2:0]  hdr_idx;
    logic [5:0]  hdr_bit;
    logic [7:0]  hdr_byte;

    udp_tx_pkg::ip_beat_t beat;
    logic                 beat_valid;

    // byte 0 sits in the top bits of the packed header
    assign hdr_idx  = frame_ptr[2:0];
    assign hdr_bit  = {~hdr_idx, 3'b000};
    assign hdr_byte = udp_hdr[hdr_bit +: 8];

    always_comb begin
        state_next     = state;
        frame_ptr_next = frame_ptr;
        hdr_ready_next = 1'b0;
        tready_next    = 1'b0;
        error_next     = 1'b0;
        store          = 1'b0;
        store_last     = 1'b0;
        beat           = '0;
        beat_valid     = 1'b0;

        case (state)
            ST_IDLE: begin
                frame_ptr_next = '0;
                hdr_ready_next = ~hdr_pending;
                if (udp_hdr_ready && udp_hdr_valid) begin
                    store          = 1'b1;
                    hdr_ready_next = 1'b0;
                    state_next     = ST_HEADER;
                    // first byte goes out right away when there is room
                    if (out_stream.ready) begin
                        beat_valid     = 1'b1;
                        beat.data      = udp_source_port_in[15:8];
                        frame_ptr_next = 16'd1;
                    end
                end
            end
            ST_HEADER: begin
                if (out_stream.ready) begin
                    beat_valid     = 1'b1;
                    beat.data      = hdr_byte;
                    frame_ptr_next = frame_ptr + 16'd1;
                    if (frame_ptr == 16'(udp_tx_pkg::UDP_HDR_BYTES - 1)) begin
                        tready_next = out_stream.ready_early;
                        state_next  = ST_PAYLOAD;
                    end
                end
            end
            ST_PAYLOAD: begin
                tready_next = out_stream.ready_early;
                beat.data   = tdata;
                beat.last   = tlast;
                beat.user   = tuser;
                beat_valid  = tvalid & tready;
                if (tvalid && tready) begin
                    frame_ptr_next = frame_ptr + 16'd1;
                    if (tlast) begin
                        // input ended short of the UDP length
                        if (frame_ptr_next != udp_hdr.length) begin
                            beat.user  = 1'b1;
                            error_next = 1'b1;
                        end
                        hdr_ready_next = ~hdr_pending;
                        tready_next    = 1'b0;
                        state_next     = ST_IDLE;
                    end else if (frame_ptr_next == udp_hdr.length) begin
                        // hold the final byte until the input frame ends
                        store_last = 1'b1;
                        beat_valid = 1'b0;
                        state_next = ST_DISCARD;
                    end
                end
            end
            ST_DISCARD: begin
                tready_next = out_stream.ready_early;
                beat.data   = last_data;
                beat.last   = tlast;
                beat.user   = tuser;
                beat_valid  = tvalid & tready & tlast;
                if (tvalid && tready && tlast) begin
                    hdr_ready_next = ~hdr_pending;
                    tready_next    = 1'b0;
                    state_next     = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state                           <= ST_IDLE;
            frame_ptr                       <= '0;
            udp_hdr_ready                   <= 1'b0;
            tready                          <= 1'b0;
            busy                            <= 1'b0;
            error_payload_early_termination <= 1'b0;
        end else begin
            state                           <= state_next;
            frame_ptr                       <= frame_ptr_next;
            udp_hdr_ready                   <= hdr_ready_next;
            tready                          <= tready_next;
            busy                            <= state_next != ST_IDLE;
            error_payload_early_termination <= error_next;
        end
    end

    always_ff @(posedge clk) begin
        if (store_last) begin
            last_data <= tdata;
        end
    end

    assign out_stream.beat  = beat;
    assign out_stream.valid = beat_valid;

endmodule

// File: verilog/udp_hdr_regs.sv
// Header capture and IP header output
module udp_hdr_regs (
    input  logic                 clk,
    input  logic                 rst,

    // one cycle pulse from the controller
    input  logic                 store,

    input  udp_tx_pkg::ip_hdr_t  ip_hdr_in,
    input  udp_tx_pkg::udp_hdr_t udp_hdr_in,

    output udp_tx_pkg::ip_hdr_t  ip_hdr_out,
    output logic [15:0]          ip_length,
    output udp_tx_pkg::udp_hdr_t udp_hdr_out,

    output logic                 ip_hdr_valid,
    input  logic                 ip_hdr_ready,
    output logic                 hdr_pending
);

    logic hdr_valid_reg;

    // valid holds until the downstream takes the header
    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_valid_reg <= 1'b0;
        end else begin
            if (store) begin
                hdr_valid_reg <= 1'b1;
            end else if (ip_hdr_ready) begin
                hdr_valid_reg <= 1'b0;
            end
        end
    end

    // header fields, loaded once per frame
    always_ff @(posedge clk) begin
        if (store) begin
            ip_hdr_out  <= ip_hdr_in;
            udp_hdr_out <= udp_hdr_in;
            // IP total length covers its own header too
            ip_length   <= udp_hdr_in.length + 16'(udp_tx_pkg::IP_HDR_BYTES);
        end
    end

    assign ip_hdr_valid = hdr_valid_reg;

    // the controller holds off the next UDP header while this is set
    assign hdr_pending = hdr_valid_reg;

endmodule

// File: verilog/byte_stream_if.sv
// Internal byte stream link
interface byte_stream_if #(
    parameter type beat_t = logic [7:0]
) ();

    beat_t beat;
    logic  valid;

    // beat is taken on any cycle with ready high
    logic  ready;

    // ready for the following cycle
    logic  ready_early;

    modport source (
        output beat,
        output valid,
        input  ready,
        input  ready_early
    );

    modport sink (
        input  beat,
        input  valid,
        output ready,
        output ready_early
    );

endinterface

// File: verilog/udp_tx_pkg.sv
// UDP transmit framer types
package udp_tx_pkg;

    // UDP header bytes sent ahead of the payload
    parameter int UDP_HDR_BYTES = 8;

    // IPv4 header without options
    parameter int IP_HDR_BYTES = 20;

    typedef logic [31:0] ip_addr_t;

    // IP fields carried through to the output header
    typedef struct packed {
        ip_addr_t    source_ip;
        ip_addr_t    dest_ip;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] identification;
    } ip_hdr_t;

    // UDP header with the first field in the top bits
    // so the packed word is already in wire order
    typedef struct packed {
        logic [15:0] source_port;
        logic [15:0] dest_port;
        logic [15:0] length;
        logic [15:0] checksum;
    } udp_hdr_t;

    // one byte of the IP payload stream
    typedef struct packed {
        logic [7:0] data;
        // end of frame
        logic       last;
        // frame is bad
        logic       user;
    } ip_beat_t;

endpackage
